/* source/cache_pkg.sv */
package cache_pkg;

    // address layout, high to low: tag | index | offset | byte
    localparam int ADDR_BITS      = 32;
    localparam int BYTE_BITS      = 3;
    localparam int OFFSET_BITS    = 4;
    localparam int INDEX_BITS     = 3;
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    localparam int WORDS_PER_LINE = 16;
    localparam int NUM_SETS       = 8;
    localparam int NUM_WAYS       = 2;
    localparam int WAY_BITS       = 1;

    localparam int LANE_BITS      = 8;
    localparam int BYTES_PER_WORD = 8;
    localparam int WORD_BITS      = BYTES_PER_WORD * LANE_BITS;

    // flat word storage, all ways and sets
    localparam int DATA_DEPTH     = NUM_WAYS * NUM_SETS * WORDS_PER_LINE;
    localparam int DATA_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]      addr_t;
    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [BYTES_PER_WORD-1:0] strobe_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [OFFSET_BITS-1:0]    offset_t;
    typedef logic [WAY_BITS-1:0]       way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FETCH,
        RESPOND
    } ctrl_state_t;

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[BYTE_BITS +: OFFSET_BITS];
    endfunction

    // byte address of one word inside a line
    function automatic addr_t line_addr(input tag_t tag, input index_t index,
                                        input offset_t offset);
        return {tag, index, offset, {BYTE_BITS{1'b0}}};
    endfunction

endpackage

/* source/cache_ports.sv */
`timescale 1ns/1ps

interface tag_port_if import cache_pkg::*; ();
    index_t index;
    tag_t   tag;
    logic   fill;
    logic   mark_dirty;
    logic   touch;
    way_t   way;
    logic   hit;
    way_t   hit_way;
    way_t   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;

    modport ctrl (output index, tag, fill, mark_dirty, touch, way,
                  input  hit, hit_way, victim_way, victim_dirty, victim_tag);
    modport array (input  index, tag, fill, mark_dirty, touch, way,
                   output hit, hit_way, victim_way, victim_dirty, victim_tag);
endinterface

interface data_port_if import cache_pkg::*; ();
    logic    write_en;
    way_t    way;
    index_t  index;
    offset_t offset;
    strobe_t strobe;
    word_t   wdata;
    word_t   rdata;

    modport ctrl (output write_en, way, index, offset, strobe, wdata, input rdata);
    modport array (input write_en, way, index, offset, strobe, wdata, output rdata);
endinterface

/* source/tag_array.sv */
`timescale 1ns/1ps

module tag_array import cache_pkg::*; (
    input logic       clk,
    input logic       reset,
    tag_port_if.array tags
);

    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty [NUM_SETS];
    tag_t                tag_mem [NUM_SETS][NUM_WAYS];
    // way to evict next in each set
    way_t                lru [NUM_SETS];

    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] match;
    way_t                hit_way;
    way_t                victim;

    assign set_valid = valid[tags.index];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = set_valid[w] && (tag_mem[tags.index][w] == tags.tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // lowest invalid way wins, else lru
    always_comb begin
        victim = lru[tags.index];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim = way_t'(w);
            end
        end
    end

    assign tags.hit          = |match;
    assign tags.hit_way      = hit_way;
    assign tags.victim_way   = victim;
    assign tags.victim_dirty = set_valid[victim] && dirty[tags.index][victim];
    assign tags.victim_tag   = tag_mem[tags.index][victim];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                lru[s]   <= '0;
            end
        end else begin
            if (tags.fill) begin
                valid[tags.index][tags.way] <= 1'b1;
            end
            // two ways, so the other one becomes lru
            if (tags.touch) begin
                lru[tags.index] <= ~tags.way;
            end
        end
    end

    // dirty only counts while the way is valid
    always_ff @(posedge clk) begin
        if (tags.fill) begin
            tag_mem[tags.index][tags.way] <= tags.tag;
            dirty[tags.index][tags.way]   <= 1'b0;
        end else if (tags.mark_dirty) begin
            dirty[tags.index][tags.way]   <= 1'b1;
        end
    end

endmodule

/* source/data_array.sv */
`timescale 1ns/1ps

module data_array import cache_pkg::*; (
    input logic        clk,
    data_port_if.array data
);

    word_t mem [DATA_DEPTH];

    logic [DATA_ADDR_BITS-1:0] word_addr;

    // way is the top bit, then set, then word
    assign word_addr = {data.way, data.index, data.offset};

    // zero latency read
    assign data.rdata = mem[word_addr];

    always_ff @(posedge clk) begin
        if (data.write_en) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (data.strobe[b]) begin
                    mem[word_addr][b*LANE_BITS +: LANE_BITS] <=
                        data.wdata[b*LANE_BITS +: LANE_BITS];
                end
            end
        end
    end

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      dreq_valid,
    input  addr_t     dreq_addr,
    input  strobe_t   dreq_strobe,
    input  word_t     dreq_data,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     rdata,

    output logic      mem_valid,
    output logic      mem_is_write,
    output addr_t     mem_addr,
    output word_t     mem_wdata,
    input  logic      mem_ready,
    input  logic      mem_last,
    input  word_t     mem_rdata,

    tag_port_if.ctrl  tags,
    data_port_if.ctrl data
);

    ctrl_state_t state;
    offset_t     beat;

    // accepted request
    addr_t   req_addr;
    strobe_t req_strobe;
    word_t   req_data;

    way_t    victim_way;
    tag_t    victim_tag;
    word_t   resp_data;

    logic    accept;
    logic    beat_done;
    logic    lookup_hit;
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;

    assign accept     = dreq_valid && addr_ok;
    assign beat_done  = mem_valid && mem_ready;
    assign lookup_hit = (state == LOOKUP) && tags.hit;

    assign req_tag    = addr_tag(req_addr);
    assign req_index  = addr_index(req_addr);
    assign req_offset = addr_offset(req_addr);

    // processor bus
    assign addr_ok = (state == IDLE);
    assign data_ok = (state == RESPOND);
    assign rdata   = resp_data;

    // memory bus, bursts start at the line base
    assign mem_valid    = (state == WRITEBACK) || (state == FETCH);
    assign mem_is_write = (state == WRITEBACK);
    assign mem_addr     = line_addr(mem_is_write ? victim_tag : req_tag, req_index, beat);
    assign mem_wdata    = data.rdata;

    // tag port
    assign tags.index      = req_index;
    assign tags.tag        = req_tag;
    assign tags.way        = (state == FETCH) ? victim_way : tags.hit_way;
    assign tags.fill       = (state == FETCH) && beat_done && mem_last;
    assign tags.touch      = lookup_hit;
    assign tags.mark_dirty = lookup_hit && (|req_strobe);

    // data port
    assign data.index  = req_index;
    assign data.way    = (state == LOOKUP) ? tags.hit_way : victim_way;
    assign data.offset = (state == LOOKUP) ? req_offset : beat;

    always_comb begin
        if (state == FETCH) begin
            data.write_en = beat_done;
            data.strobe   = '1;
            data.wdata    = mem_rdata;
        end else begin
            // store hit merges bytes in place
            data.write_en = lookup_hit && (|req_strobe);
            data.strobe   = req_strobe;
            data.wdata    = req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    beat <= '0;
                    if (tags.hit) begin
                        state <= RESPOND;
                    end else if (tags.victim_dirty) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= FETCH;
                    end
                end
                WRITEBACK: begin
                    if (beat_done) begin
                        beat <= beat + offset_t'(1);
                        if (mem_last) begin
                            state <= FETCH;
                            beat  <= '0;
                        end
                    end
                end
                FETCH: begin
                    if (beat_done) begin
                        beat <= beat + offset_t'(1);
                        // line installed, look up again
                        if (mem_last) begin
                            state <= LOOKUP;
                        end
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr   <= dreq_addr;
            req_strobe <= dreq_strobe;
            req_data   <= dreq_data;
        end
        if (lookup_hit) begin
            resp_data <= data.rdata;
        end
        // victim held for the whole miss
        if ((state == LOOKUP) && !tags.hit) begin
            victim_way <= tags.victim_way;
            victim_tag <= tags.victim_tag;
        end
    end

endmodule

/* source/dcache.sv */
`timescale 1ns/1ps

module dcache import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset,

    input  logic    dreq_valid,
    input  addr_t   dreq_addr,
    input  strobe_t dreq_strobe,
    input  word_t   dreq_data,
    output logic    dresp_addr_ok,
    output logic    dresp_data_ok,
    output word_t   dresp_data,

    output logic    creq_valid,
    output logic    creq_is_write,
    output addr_t   creq_addr,
    output word_t   creq_data,
    input  logic    cresp_ready,
    input  logic    cresp_last,
    input  word_t   cresp_data
);

    tag_port_if  tag_port ();
    data_port_if data_port ();

    cache_controller u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .dreq_valid   (dreq_valid),
        .dreq_addr    (dreq_addr),
        .dreq_strobe  (dreq_strobe),
        .dreq_data    (dreq_data),
        .addr_ok      (dresp_addr_ok),
        .data_ok      (dresp_data_ok),
        .rdata        (dresp_data),
        .mem_valid    (creq_valid),
        .mem_is_write (creq_is_write),
        .mem_addr     (creq_addr),
        .mem_wdata    (creq_data),
        .mem_ready    (cresp_ready),
        .mem_last     (cresp_last),
        .mem_rdata    (cresp_data),
        .tags         (tag_port.ctrl),
        .data         (data_port.ctrl)
    );

    tag_array u_tags (
        .clk   (clk),
        .reset (reset),
        .tags  (tag_port.array)
    );

    data_array u_data (
        .clk  (clk),
        .data (data_port.array)
    );

endmodule

/* bench/dcache_assert.sv */
`timescale 1ns/1ps

module dcache_assert import cache_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  dreq_valid,
    input logic  dresp_addr_ok,
    input logic  dresp_data_ok,
    input logic  creq_valid,
    input addr_t creq_addr,
    input word_t creq_data,
    input logic  cresp_ready
);

    int fail_count;

    hold_request: assert property (@(posedge clk) disable iff (!reset)
        dreq_valid && !dresp_addr_ok |=> dreq_valid)
        else begin
            fail_count++;
            $error("dreq_valid dropped before the request was accepted");
        end

    // stalled beat keeps address and data
    stable_burst: assert property (@(posedge clk) disable iff (!reset)
        creq_valid && !cresp_ready |=> $stable(creq_addr) && $stable(creq_data))
        else begin
            fail_count++;
            $error("creq_addr or creq_data changed during a stalled beat");
        end

    single_pulse: assert property (@(posedge clk) disable iff (!reset)
        dresp_data_ok |=> !dresp_data_ok)
        else begin
            fail_count++;
            $error("dresp_data_ok stayed high for more than one cycle");
        end

    no_resp_in_burst: assert property (@(posedge clk) disable iff (!reset)
        !(dresp_data_ok && creq_valid))
        else begin
            fail_count++;
            $error("dresp_data_ok raised while a memory burst is active");
        end

endmodule

/* bench/mem_pattern.svh */
// contents of a memory word never written, built from every address bit
function automatic word_t addr_pattern(input addr_t addr);
    return {~addr, addr ^ 32'h5a3c_96e1};
endfunction

/* bench/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    dreq_valid,
    input  addr_t   dreq_addr,
    input  strobe_t dreq_strobe,
    input  word_t   dreq_data,
    input  logic    dresp_addr_ok,
    input  logic    dresp_data_ok,
    input  word_t   dresp_data,
    input  logic    creq_valid,
    input  logic    creq_is_write,
    input  addr_t   creq_addr,
    input  word_t   creq_data,
    input  logic    cresp_ready,
    input  logic    cresp_last,
    input  int      exp_reads,
    input  int      exp_writes,
    input  logic    exp_hit,
    output int      errors
);

    `include "mem_pattern.svh"

    localparam int LINE_BITS = OFFSET_BITS + BYTE_BITS;

    // memory as the processor sees it after each accepted store
    word_t shadow [addr_t];

    addr_t   req_addr;
    strobe_t req_strobe;
    logic    pending;
    int      cycle;
    int      accept_cycle;
    int      reads;
    int      writes;
    int      beat;
    addr_t   burst_base;

    function automatic addr_t word_of(input addr_t a);
        return {a[ADDR_BITS-1:BYTE_BITS], {BYTE_BITS{1'b0}}};
    endfunction

    function automatic word_t expected_word(input addr_t a);
        if (shadow.exists(word_of(a))) begin
            return shadow[word_of(a)];
        end
        return addr_pattern(word_of(a));
    endfunction

    function automatic word_t merge_bytes(input word_t old, input strobe_t strobe,
                                          input word_t wdata);
        word_t res;
        res = old;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (strobe[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic flag_mismatch(input string name, input word_t exp, input word_t act);
        errors++;
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic flag_failure(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_beat();
        addr_t exp_addr;
        if (beat == 0) begin
            burst_base = creq_addr;
            if (creq_is_write) begin
                writes++;
            end else begin
                reads++;
            end
            if (creq_addr[LINE_BITS-1:0] != '0 ||
                creq_addr[LINE_BITS +: INDEX_BITS] != req_addr[LINE_BITS +: INDEX_BITS]) begin
                flag_failure("burst does not start at a line base in the requested set");
            end
            if (!creq_is_write &&
                creq_addr[ADDR_BITS-1:LINE_BITS] != req_addr[ADDR_BITS-1:LINE_BITS]) begin
                flag_failure("read burst fetches a line other than the requested one");
            end
        end
        exp_addr = burst_base + addr_t'(beat * BYTES_PER_WORD);
        if (creq_addr != exp_addr) begin
            flag_mismatch("creq_addr", 64'(exp_addr), 64'(creq_addr));
        end
        if (creq_is_write && creq_data != expected_word(creq_addr)) begin
            flag_mismatch("creq_data", expected_word(creq_addr), creq_data);
        end
        beat = cresp_last ? 0 : beat + 1;
    endtask

    task automatic check_response();
        if (!pending) begin
            flag_failure("dresp_data_ok with no request outstanding");
        end else begin
            pending = 1'b0;
            if (req_strobe == '0 && dresp_data != expected_word(req_addr)) begin
                flag_mismatch("dresp_data", expected_word(req_addr), dresp_data);
            end
            if (reads != exp_reads) begin
                flag_mismatch("read bursts", 64'(exp_reads), 64'(reads));
            end
            if (writes != exp_writes) begin
                flag_mismatch("write bursts", 64'(exp_writes), 64'(writes));
            end
            // hit answers two edges after acceptance
            if (exp_hit && cycle - accept_cycle != 2) begin
                flag_mismatch("hit latency", 64'd2, 64'(cycle - accept_cycle));
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            shadow.delete();
            pending = 1'b0;
            beat = 0;
        end else begin
            cycle++;
            // only one request at a time
            if (pending && dresp_addr_ok) begin
                flag_failure("dresp_addr_ok high while a request is outstanding");
            end
            if (dreq_valid && dresp_addr_ok) begin
                req_addr     = dreq_addr;
                req_strobe   = dreq_strobe;
                pending      = 1'b1;
                accept_cycle = cycle;
                reads        = 0;
                writes       = 0;
                if (|dreq_strobe) begin
                    shadow[word_of(dreq_addr)] =
                        merge_bytes(expected_word(dreq_addr), dreq_strobe, dreq_data);
                end
            end
            if (creq_valid && cresp_ready) begin
                check_beat();
            end
            if (dresp_data_ok) begin
                check_response();
            end
        end
    end

endmodule

/* bench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import cache_pkg::*; ();

    `include "mem_pattern.svh"

    localparam int NUM_ROWS       = 12;
    localparam int CYCLES_PER_ROW = 2 * WORDS_PER_LINE * 4 + 10;
    // two passes, each with its reset
    localparam int TIMEOUT_CYCLES = 2 * (NUM_ROWS * CYCLES_PER_ROW + 20);

    typedef enum bit {OP_LOAD, OP_STORE} op_t;

    typedef struct packed {
        op_t     op;
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
        int      reads;
        int      writes;
        bit      hit;
    } row_t;

    logic    clk;
    logic    reset;
    logic    dreq_valid;
    addr_t   dreq_addr;
    strobe_t dreq_strobe;
    word_t   dreq_data;
    logic    dresp_addr_ok;
    logic    dresp_data_ok;
    word_t   dresp_data;
    logic    creq_valid;
    logic    creq_is_write;
    addr_t   creq_addr;
    word_t   creq_data;
    logic    cresp_ready = 1'b0;
    logic    cresp_last = 1'b0;
    word_t   cresp_data = '0;

    int      exp_reads;
    int      exp_writes;
    logic    exp_hit;
    int      check_errors;

    row_t    rows [NUM_ROWS];
    word_t   mem_model [addr_t];
    int      beat_cnt;
    bit      stalls_on;
    integer  seed;
    int      cycles;

    dcache dut (.*);

    dcache_checker chk (.*, .errors(check_errors));

    bind dcache dcache_assert assert_mon (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // set 0 lines: 0x1000, 0x1400, 0x1800, 0x1c00
    task automatic load_table();
        rows[0]  = '{OP_LOAD,  32'h0000_1018, 8'h00, 64'h0, 1, 0, 1'b0};
        rows[1]  = '{OP_LOAD,  32'h0000_1020, 8'h00, 64'h0, 0, 0, 1'b1};
        rows[2]  = '{OP_STORE, 32'h0000_1028, 8'h0f, 64'h1122_3344_5566_7788, 0, 0, 1'b1};
        rows[3]  = '{OP_LOAD,  32'h0000_1028, 8'h00, 64'h0, 0, 0, 1'b1};
        rows[4]  = '{OP_LOAD,  32'h0000_1408, 8'h00, 64'h0, 1, 0, 1'b0};
        rows[5]  = '{OP_LOAD,  32'h0000_1810, 8'h00, 64'h0, 1, 1, 1'b0};
        rows[6]  = '{OP_LOAD,  32'h0000_1028, 8'h00, 64'h0, 1, 0, 1'b0};
        rows[7]  = '{OP_STORE, 32'h0000_1830, 8'hf0, 64'hcafe_f00d_dead_beef, 0, 0, 1'b1};
        rows[8]  = '{OP_STORE, 32'h0000_1c00, 8'hff, 64'h0123_4567_89ab_cdef, 1, 0, 1'b0};
        rows[9]  = '{OP_LOAD,  32'h0000_1028, 8'h00, 64'h0, 1, 1, 1'b0};
        rows[10] = '{OP_LOAD,  32'h0000_1830, 8'h00, 64'h0, 1, 1, 1'b0};
        rows[11] = '{OP_LOAD,  32'h0000_2080, 8'h00, 64'h0, 1, 0, 1'b0};
    endtask

    function automatic word_t mem_read(input addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return addr_pattern(a);
    endfunction

    // burst memory, inputs change 1 ns after the edge
    always @(posedge clk) begin
        if (!reset) begin
            mem_model.delete();
            beat_cnt = 0;
        end else if (creq_valid && cresp_ready) begin
            if (creq_is_write) begin
                mem_model[creq_addr] = creq_data;
            end
            beat_cnt = cresp_last ? 0 : beat_cnt + 1;
        end
        #1;
        cresp_ready = stalls_on ? ($random(seed) % 4 != 0) : 1'b1;
        cresp_last  = cresp_ready && creq_valid && (beat_cnt == WORDS_PER_LINE - 1);
        cresp_data  = (creq_valid && !creq_is_write) ? mem_read(creq_addr) : '0;
    end

    task automatic apply_reset();
        reset = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;
    endtask

    task automatic apply_row(input row_t r);
        exp_reads   = r.reads;
        exp_writes  = r.writes;
        exp_hit     = r.hit;
        dreq_valid  = 1'b1;
        dreq_addr   = r.addr;
        dreq_strobe = (r.op == OP_STORE) ? r.strobe : '0;
        dreq_data   = r.data;
        @(posedge clk);
        while (!dresp_addr_ok) @(posedge clk);
        #1;
        dreq_valid = 1'b0;
        @(posedge clk);
        while (!dresp_data_ok) @(posedge clk);
        #1;
    endtask

    task automatic run_pass();
        apply_reset();
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end
    endtask

    task automatic report_counts();
        $display("errors: checker %0d, assertions %0d",
                 check_errors, dut.assert_mon.fail_count);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run was still busy after %0d cycles", cycles);
        report_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset       = 1'b0;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_strobe = '0;
        dreq_data   = '0;
        exp_reads   = 0;
        exp_writes  = 0;
        exp_hit     = 1'b0;
        stalls_on   = 1'b0;
        seed        = 48;
        load_table();
        run_pass();
        // same rows again with random ready stalls
        stalls_on = 1'b1;
        run_pass();
        repeat (2) @(posedge clk);
        report_counts();
        if (check_errors == 0 && dut.assert_mon.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+bench
source/cache_pkg.sv
source/cache_ports.sv
source/tag_array.sv
source/data_array.sv
source/cache_controller.sv
source/dcache.sv
bench/dcache_assert.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
